// File: Makefile
# Verilator build and run for the FX2 command controller testbench

VERILATOR ?= verilator
TOP       ?= tb_fx2_controller
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
TIMESCALE ?= 1ns/1ps
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
SIM_BIN   := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR TIMESCALE VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)

// File: hdl/cmd_executor.sv
// Command executor holding the HWCON registers and driving the I/O module register bus
`timescale 1ns/1ps

module cmd_executor #(
    parameter int MAX_CMD_BYTES = fx2_ctrl_pkg::DEFAULT_MAX_CMD_BYTES
) (
    input  logic                                     clk,
    input  logic                                     reset,
    input  logic [fx2_ctrl_pkg::NUM_PORTS-1:0]       direction,
    cmd_msg_if.sink                                  cmd,
    cmd_msg_if.source                                reply,
    output logic [fx2_ctrl_pkg::NUM_IO_MODULES-1:0]  cfg_io_write,
    output logic [fx2_ctrl_pkg::NUM_IO_MODULES-1:0]  cfg_io_read,
    output fx2_ctrl_pkg::ioreg_addr_t                cfg_io_addr,
    output fx2_ctrl_pkg::byte_t                      cfg_io_wdata,
    input  fx2_ctrl_pkg::byte_t                      cfg_io_rdata,
    output logic [8*fx2_ctrl_pkg::NUM_PORTS-1:0]     hwcons
);
    import fx2_ctrl_pkg::*;

    localparam int PAYLOAD_W = 8 * MAX_CMD_BYTES;
    localparam int INDEX_W   = $clog2(NUM_IO_MODULES);

    typedef enum logic [1:0] {
        EX_IDLE,
        EX_IO,
        EX_REPLY
    } state_t;

    state_t                     state;
    byte_t                      hwcon [NUM_PORTS];
    port_t                      cmd_port;
    port_t                      io_port;
    logic [INDEX_W-1:0]         io_index;
    logic                       io_is_write;
    logic [NUM_IO_MODULES-1:0]  io_select;
    logic                       accept;

    // Every kept command names its port in byte 0
    assign cmd_port = cmd.payload[1:0];

    // New commands only while nothing is in flight
    assign cmd.ready = (state == EX_IDLE);
    assign accept    = cmd.valid && cmd.ready;

    // One strobe cycle per I/O access, at module {direction, port}
    assign io_select    = NUM_IO_MODULES'(1) << io_index;
    assign cfg_io_write = ((state == EX_IO) && io_is_write) ? io_select : '0;
    assign cfg_io_read  = ((state == EX_IO) && !io_is_write) ? io_select : '0;

    for (genvar g = 0; g < NUM_PORTS; g++) begin : g_hwcons
        assign hwcons[8*g +: 8] = hwcon[g];
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state       <= EX_IDLE;
            reply.valid <= 1'b0;
            for (int i = 0; i < NUM_PORTS; i++) begin
                hwcon[i] <= '0;
            end
        end else begin
            case (state)
                EX_IDLE: begin
                    if (accept) begin
                        case (cmd.id)
                            CMD_SET_HWCON: hwcon[cmd_port] <= cmd.payload[15:8];
                            CMD_GET_HWCON: begin
                                state       <= EX_REPLY;
                                reply.valid <= 1'b1;
                            end
                            CMD_GET_IOREG,
                            CMD_SET_IOREG: state <= EX_IO;
                            // Unknown IDs are consumed without reply
                            default: state <= EX_IDLE;
                        endcase
                    end
                end
                EX_IO: begin
                    if (io_is_write) begin
                        state <= EX_IDLE;
                    end else begin
                        state       <= EX_REPLY;
                        reply.valid <= 1'b1;
                    end
                end
                EX_REPLY: begin
                    if (reply.ready) begin
                        state       <= EX_IDLE;
                        reply.valid <= 1'b0;
                    end
                end
                default: state <= EX_IDLE;
            endcase
        end
    end

    // Access parameters and reply assembly
    always_ff @(posedge clk) begin
        if (accept) begin
            io_port      <= cmd_port;
            io_index     <= {direction[cmd_port], cmd_port};
            io_is_write  <= (cmd.id == CMD_SET_IOREG);
            cfg_io_addr  <= cmd.payload[9:8];
            cfg_io_wdata <= cmd.payload[23:16];
            if (cmd.id == CMD_GET_HWCON) begin
                reply.id      <= CMD_DATA_HWCON;
                reply.length  <= HWCON_REPLY_LEN;
                reply.payload <= PAYLOAD_W'({6'b0, cmd_port, hwcon[cmd_port]});
            end
        end
        // Read data is taken at the edge that ends the read strobe
        if ((state == EX_IO) && !io_is_write) begin
            reply.id      <= CMD_DATA_IOREG;
            reply.length  <= IOREG_REPLY_LEN;
            reply.payload <= PAYLOAD_W'({6'b0, io_port, 6'b0, cfg_io_addr, cfg_io_rdata});
        end
    end

endmodule

// File: hdl/cmd_msg_if.sv
// Packet channel carrying one command or reply with header and payload between blocks
`timescale 1ns/1ps

interface cmd_msg_if #(
    parameter int MAX_CMD_BYTES = fx2_ctrl_pkg::DEFAULT_MAX_CMD_BYTES
);
    import fx2_ctrl_pkg::*;

    // Transfer happens when valid and ready are both high at a clock edge
    logic                         valid;
    logic                         ready;
    cmd_id_t                      id;
    length_t                      length;
    // Byte i sits at bits 8i+7 down to 8i
    logic [8*MAX_CMD_BYTES-1:0]   payload;

    modport source (
        output valid,
        output id,
        output length,
        output payload,
        input  ready
    );

    modport sink (
        input  valid,
        input  id,
        input  length,
        input  payload,
        output ready
    );

endinterface

// File: hdl/cmd_reader.sv
// EP4 command reader collecting one packet byte by byte into a payload buffer
`timescale 1ns/1ps

module cmd_reader #(
    parameter int MAX_CMD_BYTES = fx2_ctrl_pkg::DEFAULT_MAX_CMD_BYTES
) (
    input  logic                  clk,
    input  logic                  reset,
    input  fx2_ctrl_pkg::byte_t   ep4_cmd_id,
    input  fx2_ctrl_pkg::length_t ep4_cmd_length,
    input  logic                  ep4_ready,
    input  fx2_ctrl_pkg::byte_t   ep4_data,
    output logic                  ep4_read,
    cmd_msg_if.source             cmd
);
    import fx2_ctrl_pkg::*;

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_ACTIVE,
        RD_DONE
    } state_t;

    state_t  state;
    length_t count;
    logic    start;
    logic    finish;

    // A new packet starts as soon as the FX2 side has one available
    assign start = (state == RD_IDLE) && ep4_ready;

    // All bytes of the header length have been taken
    assign finish = (state == RD_ACTIVE) && (count >= ep4_cmd_length);

    assign ep4_read = (state == RD_ACTIVE) && !finish && ep4_ready;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state     <= RD_IDLE;
            count     <= '0;
            cmd.valid <= 1'b0;
        end else begin
            case (state)
                RD_IDLE: begin
                    if (start) begin
                        state <= RD_ACTIVE;
                        count <= '0;
                    end
                end
                RD_ACTIVE: begin
                    if (finish) begin
                        state     <= RD_DONE;
                        cmd.valid <= 1'b1;
                    end else if (ep4_read) begin
                        count <= count + 1'b1;
                    end
                end
                RD_DONE: begin
                    // Hold the packet until the executor takes it
                    if (cmd.ready) begin
                        state     <= RD_IDLE;
                        cmd.valid <= 1'b0;
                    end
                end
                default: state <= RD_IDLE;
            endcase
        end
    end

    // Payload buffer, header capture
    always_ff @(posedge clk) begin
        if (start) begin
            cmd.payload <= '0;
        end else if (ep4_read) begin
            // Bytes past the buffer end are read and dropped
            for (int i = 0; i < MAX_CMD_BYTES; i++) begin
                if (count == length_t'(i)) begin
                    cmd.payload[8*i +: 8] <= ep4_data;
                end
            end
        end
        if (finish) begin
            cmd.id     <= cmd_id_t'(ep4_cmd_id);
            cmd.length <= ep4_cmd_length;
        end
    end

endmodule

// File: hdl/fx2_controller.sv
// FX2 command controller top connecting EP4 reader, executor and EP8 writer
`timescale 1ns/1ps

module fx2_controller #(
    parameter int MAX_CMD_BYTES = fx2_ctrl_pkg::DEFAULT_MAX_CMD_BYTES
) (
    input  logic                                     clk,
    input  logic                                     reset,
    // EP4 command stream
    input  fx2_ctrl_pkg::byte_t                      ep4_cmd_id,
    input  fx2_ctrl_pkg::length_t                    ep4_cmd_length,
    input  logic                                     ep4_ready,
    input  fx2_ctrl_pkg::byte_t                      ep4_data,
    output logic                                     ep4_read,
    // EP8 reply stream
    output fx2_ctrl_pkg::byte_t                      ep8_cmd_id,
    output fx2_ctrl_pkg::length_t                    ep8_cmd_length,
    output logic                                     ep8_write,
    output fx2_ctrl_pkg::byte_t                      ep8_data,
    input  logic                                     ep8_ready,
    // I/O module register bus
    output logic [fx2_ctrl_pkg::NUM_IO_MODULES-1:0]  cfg_io_write,
    output logic [fx2_ctrl_pkg::NUM_IO_MODULES-1:0]  cfg_io_read,
    output fx2_ctrl_pkg::ioreg_addr_t                cfg_io_addr,
    output fx2_ctrl_pkg::byte_t                      cfg_io_wdata,
    input  fx2_ctrl_pkg::byte_t                      cfg_io_rdata,
    input  logic [fx2_ctrl_pkg::NUM_PORTS-1:0]       direction,
    // Per-port hardware configuration
    output logic [8*fx2_ctrl_pkg::NUM_PORTS-1:0]     hwcons
);

    cmd_msg_if #(.MAX_CMD_BYTES(MAX_CMD_BYTES)) cmd_bus ();
    cmd_msg_if #(.MAX_CMD_BYTES(MAX_CMD_BYTES)) reply_bus ();

    cmd_reader #(
        .MAX_CMD_BYTES (MAX_CMD_BYTES)
    ) u_reader (
        .clk            (clk),
        .reset          (reset),
        .ep4_cmd_id     (ep4_cmd_id),
        .ep4_cmd_length (ep4_cmd_length),
        .ep4_ready      (ep4_ready),
        .ep4_data       (ep4_data),
        .ep4_read       (ep4_read),
        .cmd            (cmd_bus.source)
    );

    cmd_executor #(
        .MAX_CMD_BYTES (MAX_CMD_BYTES)
    ) u_executor (
        .clk          (clk),
        .reset        (reset),
        .direction    (direction),
        .cmd          (cmd_bus.sink),
        .reply        (reply_bus.source),
        .cfg_io_write (cfg_io_write),
        .cfg_io_read  (cfg_io_read),
        .cfg_io_addr  (cfg_io_addr),
        .cfg_io_wdata (cfg_io_wdata),
        .cfg_io_rdata (cfg_io_rdata),
        .hwcons       (hwcons)
    );

    reply_writer #(
        .MAX_CMD_BYTES (MAX_CMD_BYTES)
    ) u_writer (
        .clk            (clk),
        .reset          (reset),
        .reply          (reply_bus.sink),
        .ep8_cmd_id     (ep8_cmd_id),
        .ep8_cmd_length (ep8_cmd_length),
        .ep8_write      (ep8_write),
        .ep8_data       (ep8_data),
        .ep8_ready      (ep8_ready)
    );

endmodule

// File: hdl/fx2_ctrl_pkg.sv
// FX2 command controller package with command codes, field widths and shared types
package fx2_ctrl_pkg;

    // One byte on the EP4/EP8 streams and the I/O register bus
    typedef logic [7:0] byte_t;

    // Packet length in bytes, as carried in the FX2 packet header
    typedef logic [15:0] length_t;

    // Port number and register address inside an I/O module
    typedef logic [1:0] port_t;
    typedef logic [1:0] ioreg_addr_t;

    // Command and reply codes
    typedef enum logic [7:0] {
        CMD_NONE       = 8'h00,
        CMD_GET_HWCON  = 8'h33,
        CMD_SET_HWCON  = 8'h34,
        CMD_GET_IOREG  = 8'h35,
        CMD_SET_IOREG  = 8'h36,
        CMD_DATA_HWCON = 8'h91,
        CMD_DATA_IOREG = 8'h92
    } cmd_id_t;

    // Number of ports, one HWCON register each
    localparam int NUM_PORTS = 4;

    // I/O modules are indexed by {direction, port}
    localparam int NUM_IO_MODULES = 8;

    // Payload buffer capacity unless the top level says otherwise
    localparam int DEFAULT_MAX_CMD_BYTES = 8;

    // Reply lengths
    localparam length_t HWCON_REPLY_LEN = 16'd2;
    localparam length_t IOREG_REPLY_LEN = 16'd3;

endpackage

// File: hdl/reply_writer.sv
// EP8 reply writer sending a packet's payload highest byte first under flow control
`timescale 1ns/1ps

module reply_writer #(
    parameter int MAX_CMD_BYTES = fx2_ctrl_pkg::DEFAULT_MAX_CMD_BYTES
) (
    input  logic                  clk,
    input  logic                  reset,
    cmd_msg_if.sink               reply,
    output fx2_ctrl_pkg::byte_t   ep8_cmd_id,
    output fx2_ctrl_pkg::length_t ep8_cmd_length,
    output logic                  ep8_write,
    output fx2_ctrl_pkg::byte_t   ep8_data,
    input  logic                  ep8_ready
);
    import fx2_ctrl_pkg::*;

    logic    busy;
    length_t count;
    length_t byte_index;
    logic    last_byte;

    // Header is visible only while a reply is pending
    assign ep8_cmd_id     = reply.valid ? byte_t'(reply.id) : byte_t'(CMD_NONE);
    assign ep8_cmd_length = reply.valid ? reply.length : '0;

    // Count holds the number of bytes still to go
    assign ep8_write  = busy && (count != '0) && ep8_ready;
    assign byte_index = count - 1'b1;
    assign last_byte  = ep8_write && (count == length_t'(1));

    // Empty replies complete right after loading
    assign reply.ready = busy && (last_byte || (count == '0));

    always_comb begin
        ep8_data = '0;
        for (int i = 0; i < MAX_CMD_BYTES; i++) begin
            if (byte_index == length_t'(i)) begin
                ep8_data = reply.payload[8*i +: 8];
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            busy  <= 1'b0;
            count <= '0;
        end else if (!busy) begin
            if (reply.valid) begin
                busy  <= 1'b1;
                count <= reply.length;
            end
        end else if (reply.ready) begin
            busy  <= 1'b0;
            count <= '0;
        end else if (ep8_write) begin
            // Stalls while ep8_ready is low, nothing is skipped
            count <= count - 1'b1;
        end
    end

endmodule

// File: tb.f
hdl/fx2_ctrl_pkg.sv
hdl/cmd_msg_if.sv
hdl/cmd_reader.sv
hdl/cmd_executor.sv
hdl/reply_writer.sv
hdl/fx2_controller.sv
test/fx2_controller_sva.sv
test/tb_fx2_controller.sv

// File: test/fx2_controller_sva.sv
// Protocol assertions on the FX2 controller top-level stream and I/O bus ports
`timescale 1ns/1ps

module fx2_controller_sva (
    input logic                                     clk,
    input logic                                     reset,
    input logic                                     ep4_read,
    input logic                                     ep4_ready,
    input logic                                     ep8_write,
    input logic                                     ep8_ready,
    input fx2_ctrl_pkg::byte_t                      ep8_cmd_id,
    input logic [fx2_ctrl_pkg::NUM_IO_MODULES-1:0]  cfg_io_write,
    input logic [fx2_ctrl_pkg::NUM_IO_MODULES-1:0]  cfg_io_read
);

    // Each strobe selects at most one I/O module
    a_write_onehot: assert property (@(posedge clk) disable iff (reset) $onehot0(cfg_io_write))
        else $error("cfg_io_write selects more than one I/O module");

    a_read_onehot: assert property (@(posedge clk) disable iff (reset) $onehot0(cfg_io_read))
        else $error("cfg_io_read selects more than one I/O module");

    a_no_overlap: assert property (@(posedge clk) disable iff (reset)
        !((|cfg_io_write) && (|cfg_io_read)))
        else $error("read and write strobes active together");

    // EP8 bytes only move under flow control with a reply header shown
    a_ep8_write: assert property (@(posedge clk) disable iff (reset)
        ep8_write |-> (ep8_ready && ep8_cmd_id != 8'h00))
        else $error("ep8_write without ep8_ready or reply header");

    a_ep4_read: assert property (@(posedge clk) disable iff (reset) ep4_read |-> ep4_ready)
        else $error("ep4_read while no EP4 packet is available");

endmodule

bind fx2_controller fx2_controller_sva sva (
    .clk          (clk),
    .reset        (reset),
    .ep4_read     (ep4_read),
    .ep4_ready    (ep4_ready),
    .ep8_write    (ep8_write),
    .ep8_ready    (ep8_ready),
    .ep8_cmd_id   (ep8_cmd_id),
    .cfg_io_write (cfg_io_write),
    .cfg_io_read  (cfg_io_read)
);

// File: test/tb_fx2_controller.sv
// Testbench for the FX2 command controller with EP4, EP8 and I/O module models
`timescale 1ns/1ps

module tb_fx2_controller;
    import fx2_ctrl_pkg::*;

    localparam logic [31:0] SEED   = 32'ha1a37502;
    localparam int ROUNDS          = 6;
    localparam int OPS_PER_ROUND   = 8;
    localparam int NUM_COMMANDS    = ROUNDS * (2 * OPS_PER_ROUND + 1);
    localparam int TIMEOUT_CYCLES  = 200 * NUM_COMMANDS + 100;

    logic        clk;
    logic        reset;
    byte_t       ep4_cmd_id;
    length_t     ep4_cmd_length;
    logic        ep4_ready;
    byte_t       ep4_data;
    logic        ep4_read;
    byte_t       ep8_cmd_id;
    length_t     ep8_cmd_length;
    logic        ep8_write;
    byte_t       ep8_data;
    logic        ep8_ready;
    logic [7:0]  cfg_io_write;
    logic [7:0]  cfg_io_read;
    ioreg_addr_t cfg_io_addr;
    byte_t       cfg_io_wdata;
    byte_t       cfg_io_rdata;
    logic [3:0]  direction;
    logic [31:0] hwcons;

    logic [31:0] stim_lfsr;
    logic [31:0] ready_lfsr;
    byte_t       hwcon_shadow [4];
    byte_t       io_shadow [8][4];
    byte_t       io_regs [8][4];
    // Expected replies as {id, length, bytes 2..0}
    logic [47:0] exp_replies [$];
    // Expected writes as {index, addr, data}
    logic [12:0] exp_writes [$];
    logic [47:0] cur_reply;
    int          byte_count;
    int          replies_expected;
    int          replies_seen;
    int          cycle_count;
    int          error_count;

    fx2_controller #(.MAX_CMD_BYTES(8)) dut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            stim_lfsr = lfsr_step(stim_lfsr);
            r = {r[30:0], stim_lfsr[0]};
        end
        return r;
    endfunction

    function automatic byte_t fill_value(input logic [2:0] idx, input logic [1:0] addr);
        return 8'({idx, addr}) * 8'd29 + 8'h5a;
    endfunction

    // Tracks the register shadows and gives the reply a command should produce
    function automatic logic expected_reply(input byte_t id, input logic [23:0] f,
                                            output logic [47:0] reply);
        port_t       p;
        ioreg_addr_t a;
        logic [2:0]  idx;
        p = f[1:0];
        a = f[9:8];
        idx = {direction[p], p};
        reply = '0;
        expected_reply = 1'b0;
        case (id)
            8'h34: hwcon_shadow[p] = f[15:8];
            8'h36: io_shadow[idx][a] = f[23:16];
            8'h33: begin
                reply = {8'h91, 16'd2, 8'h00, 6'b0, p, hwcon_shadow[p]};
                expected_reply = 1'b1;
            end
            8'h35: begin
                reply = {8'h92, 16'd3, 6'b0, p, 6'b0, a, io_shadow[idx][a]};
                expected_reply = 1'b1;
            end
            default: expected_reply = 1'b0;
        endcase
    endfunction

    task automatic fail_run();
        error_count++;
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic report_mismatch(input string name, input logic [47:0] got,
                                   input logic [47:0] exp);
        $display("FAIL t=%0t %s got %0h expected %0h", $time, name, got, exp);
        fail_run();
    endtask

    task automatic report_error(input string msg);
        $display("ERROR t=%0t %s", $time, msg);
        fail_run();
    endtask

    // FX2 EP4 model that fills bytes past the third one with random data
    task automatic send_packet(input byte_t id, input int len, input logic [23:0] f);
        int   sent;
        logic xfer;
        sent = 0;
        ep4_cmd_id     <= id;
        ep4_cmd_length <= length_t'(len);
        ep4_data       <= f[7:0];
        ep4_ready      <= 1'b1;
        while (sent < len) begin
            @(negedge clk);
            xfer = ep4_read;
            @(posedge clk);
            if (xfer) begin
                sent++;
                if (sent == len) begin
                    ep4_ready <= 1'b0;
                end else if (sent < 3) begin
                    ep4_data <= f[8*sent +: 8];
                end else begin
                    ep4_data <= 8'(rand_bits(8));
                end
            end
        end
        // Header holds until the reader latches it on the following edge
        @(posedge clk);
    endtask

    task automatic issue(input byte_t id, input int len, input logic [23:0] f);
        logic [47:0] reply;
        logic        has_reply;
        has_reply = expected_reply(id, f, reply);
        if (has_reply) begin
            exp_replies.push_back(reply);
            replies_expected++;
        end
        if (id == 8'h36) begin
            exp_writes.push_back({direction[f[1:0]], f[1:0], f[9:8], f[23:16]});
        end
        send_packet(id, len, f);
    endtask

    // I/O module model
    always @(posedge clk) begin
        for (int i = 0; i < 8; i++) begin
            if (cfg_io_write[i]) io_regs[i][cfg_io_addr] <= cfg_io_wdata;
        end
    end

    always_comb begin
        cfg_io_rdata = '0;
        for (int i = 0; i < 8; i++) begin
            if (cfg_io_read[i]) cfg_io_rdata = io_regs[i][cfg_io_addr];
        end
    end

    // EP8 model with ready held high in reset and low about one cycle in four after it
    always @(posedge clk) begin
        logic [1:0] bits;
        for (int i = 0; i < 2; i++) begin
            ready_lfsr = lfsr_step(ready_lfsr);
            bits[i] = ready_lfsr[0];
        end
        ep8_ready <= reset ? 1'b1 : (bits != 2'b00);
    end

    // Reply checker
    always @(negedge clk) begin
        logic [7:0] exp_byte;
        if (!reset && ep8_write) begin
            assert (ep8_ready) else report_error("ep8_write high while ep8_ready is low");
            if (byte_count == 0) begin
                assert (exp_replies.size() > 0) else report_error("reply with none expected");
                cur_reply = exp_replies.pop_front();
            end
            assert (ep8_cmd_id == cur_reply[47:40])
                else report_mismatch("ep8_cmd_id", ep8_cmd_id, cur_reply[47:40]);
            assert (ep8_cmd_length == cur_reply[39:24])
                else report_mismatch("ep8_cmd_length", ep8_cmd_length, cur_reply[39:24]);
            exp_byte = cur_reply[8*(int'(cur_reply[39:24]) - 1 - byte_count) +: 8];
            assert (ep8_data == exp_byte) else report_mismatch("ep8_data", ep8_data, exp_byte);
            byte_count++;
            if (byte_count == int'(cur_reply[39:24])) begin
                byte_count = 0;
                replies_seen++;
            end
        end
    end

    // I/O write strobe checker
    always @(negedge clk) begin
        logic [12:0] w;
        if (!reset && cfg_io_write != '0) begin
            assert (exp_writes.size() > 0) else report_error("unexpected cfg_io_write strobe");
            w = exp_writes.pop_front();
            assert (cfg_io_write == 8'(1) << w[12:10])
                else report_mismatch("cfg_io_write", cfg_io_write, 8'(1) << w[12:10]);
            assert (cfg_io_addr == w[9:8])
                else report_mismatch("cfg_io_addr", cfg_io_addr, w[9:8]);
            assert (cfg_io_wdata == w[7:0])
                else report_mismatch("cfg_io_wdata", cfg_io_wdata, w[7:0]);
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES) report_error("timeout, replies stopped arriving");
    end

    initial begin
        logic [1:0]  op;
        logic [23:0] f;
        byte_t       unknown_id;
        logic [31:0] exp_hw;
        reset = 1'b1;
        ep4_cmd_id = '0;
        ep4_cmd_length = '0;
        // Both stream partners are ready through reset
        ep4_ready = 1'b1;
        ep4_data = '0;
        ep8_ready = 1'b1;
        direction = '0;
        stim_lfsr = SEED;
        ready_lfsr = SEED;
        byte_count = 0;
        replies_expected = 0;
        replies_seen = 0;
        cycle_count = 0;
        error_count = 0;
        for (int i = 0; i < 8; i++) begin
            for (int j = 0; j < 4; j++) begin
                io_regs[i][j] = fill_value(3'(i), 2'(j));
                io_shadow[i][j] = fill_value(3'(i), 2'(j));
            end
        end
        for (int i = 0; i < 4; i++) hwcon_shadow[i] = '0;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        assert (!ep4_read && !ep8_write) else report_error("stream strobe high after reset");
        assert (cfg_io_write == '0) else report_mismatch("cfg_io_write", cfg_io_write, 0);
        assert (cfg_io_read == '0) else report_mismatch("cfg_io_read", cfg_io_read, 0);
        assert (hwcons == '0) else report_mismatch("hwcons", hwcons, 0);
        @(posedge clk);
        // The empty packet offered during reset is consumed as an unknown command
        ep4_ready <= 1'b0;
        for (int r = 0; r < ROUNDS; r++) begin
            direction <= 4'(rand_bits(4));
            @(posedge clk);
            for (int k = 0; k < OPS_PER_ROUND; k++) begin
                op = 2'(rand_bits(2));
                f = 24'(rand_bits(24));
                case (op)
                    2'd0: begin
                        issue(8'h34, 2, f);
                        issue(8'h33, 1, f);
                    end
                    2'd1: begin
                        issue(8'h36, 3, f);
                        issue(8'h35, 2, f);
                    end
                    2'd2: begin
                        unknown_id = 8'(rand_bits(8));
                        if (unknown_id inside {[8'h33:8'h36]}) unknown_id = 8'hc7;
                        issue(unknown_id, 1 + int'(rand_bits(4)), f);
                        issue(8'h33, 1, f);
                    end
                    default: begin
                        issue(8'h35, 2, f);
                        issue(8'h33, 1, f);
                    end
                endcase
            end
            // The last reply of the round marks that every command has run
            issue(8'h33, 1, 24'(rand_bits(24)));
            while (replies_seen != replies_expected) @(posedge clk);
            for (int i = 0; i < 4; i++) exp_hw[8*i +: 8] = hwcon_shadow[i];
            assert (hwcons == exp_hw) else report_mismatch("hwcons", hwcons, exp_hw);
            assert (exp_writes.size() == 0) else report_error("missing cfg_io_write strobe");
        end
        if (error_count == 0) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            fail_run();
        end
    end

endmodule
